/* logic/boot_sequencer.sv */
// Starts memory 0 then core 0 once after reset; boot_done holds until the next reset
`timescale 1ns/1ps

module boot_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem0_stopped,
    input  logic                 core0_stopped,
    output logic                 boot_req,
    output sysctrl_pkg::tgt_id_t boot_tgt,
    output sysctrl_pkg::cmd_t    boot_cmd,
    input  logic                 boot_gnt,
    output logic                 boot_done
);
    import sysctrl_pkg::*;

    typedef enum logic [2:0] {
        S_MEM_REQ,
        S_MEM_WAIT,
        S_CORE_REQ,
        S_CORE_WAIT,
        S_DONE
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_MEM_REQ;
        end else begin
            case (state)
                S_MEM_REQ: begin
                    if (boot_gnt) begin
                        state <= S_MEM_WAIT;
                    end
                end
                S_MEM_WAIT: begin
                    if (!mem0_stopped) begin
                        state <= S_CORE_REQ;
                    end
                end
                S_CORE_REQ: begin
                    if (boot_gnt) begin
                        state <= S_CORE_WAIT;
                    end
                end
                S_CORE_WAIT: begin
                    if (!core0_stopped) begin
                        state <= S_DONE;
                    end
                end
                default: begin
                    state <= S_DONE;
                end
            endcase
        end
    end

    assign boot_req  = (state == S_MEM_REQ) || (state == S_CORE_REQ);
    assign boot_tgt  = (state == S_CORE_REQ) ? tgt_id_t'(CORE_BASE_ID) : tgt_id_t'(MEM_BASE_ID);
    assign boot_cmd  = CMD_RESUME;
    assign boot_done = (state == S_DONE);

endmodule

/* logic/maestro_cmd_arbiter.sv */
// Fixed priority to the boot sequencer; an APB request to a busy maestro is rejected at once
`timescale 1ns/1ps

module maestro_cmd_arbiter (
    input  logic                 boot_req,
    input  sysctrl_pkg::tgt_id_t boot_tgt,
    input  sysctrl_pkg::cmd_t    boot_cmd,
    output logic                 boot_gnt,
    input  logic                 apb_req,
    input  sysctrl_pkg::tgt_id_t apb_tgt,
    input  sysctrl_pkg::cmd_t    apb_cmd,
    output logic                 apb_gnt,
    output logic                 apb_busy,
    input  logic                 tgt_idle [sysctrl_pkg::NUM_TARGETS],
    output logic                 tgt_load [sysctrl_pkg::NUM_TARGETS],
    output sysctrl_pkg::cmd_t    tgt_cmd
);
    import sysctrl_pkg::*;

    logic                   apb_turn;
    logic [NUM_TARGETS-1:0] load_vec;

    // Boot waits for an idle maestro instead of being rejected
    assign boot_gnt = boot_req && tgt_idle[boot_tgt];

    assign apb_turn = apb_req && !boot_req;
    assign apb_gnt  = apb_turn && tgt_idle[apb_tgt];
    assign apb_busy = apb_turn && !tgt_idle[apb_tgt];

    assign tgt_cmd = boot_req ? boot_cmd : apb_cmd;

    always_comb begin
        for (int i = 0; i < NUM_TARGETS; i++) begin
            load_vec[i] = (boot_gnt && (boot_tgt == tgt_id_t'(i))) ||
                          (apb_gnt && (apb_tgt == tgt_id_t'(i)));
            tgt_load[i] = load_vec[i];
        end
    end

    // Both requesters share one command bus
    always_comb begin
        a_single_load: assert ($onehot0(load_vec))
        else $error("more than one maestro loaded");
    end

endmodule

/* logic/sysctrl_pkg.sv */
// Register indices are word addresses (byte address / 4) and every access is a full 32-bit word
package sysctrl_pkg;

    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    localparam int NUM_MEMS    = 2;
    localparam int NUM_PERIPHS = 4;
    localparam int NUM_CORES   = 2;
    localparam int NUM_TARGETS = NUM_MEMS + NUM_PERIPHS + NUM_CORES;

    // Flat target order is memories, peripherals, cores
    localparam int MEM_BASE_ID    = 0;
    localparam int PERIPH_BASE_ID = MEM_BASE_ID + NUM_MEMS;
    localparam int CORE_BASE_ID   = PERIPH_BASE_ID + NUM_PERIPHS;

    typedef logic [2:0] tgt_id_t;
    typedef logic [2:0] cmd_t;

    localparam cmd_t CMD_NONE   = 3'd0;
    localparam cmd_t CMD_RESUME = 3'd1;
    localparam cmd_t CMD_PAUSE  = 3'd2;
    localparam cmd_t CMD_STOP   = 3'd3;
    localparam cmd_t CMD_RESET  = 3'd4;

    localparam int STAT_PAUSED_BIT  = 0;
    localparam int STAT_STOPPED_BIT = 1;

    // Word index map
    localparam int MEM_REG_BASE    = 'h100;
    localparam int MEM_STRIDE      = 2;
    localparam int MEM_REG_END     = MEM_REG_BASE + NUM_MEMS * MEM_STRIDE;
    localparam int PERIPH_REG_BASE = 'h200;
    localparam int PERIPH_STRIDE   = 2;
    localparam int PERIPH_REG_END  = PERIPH_REG_BASE + NUM_PERIPHS * PERIPH_STRIDE;
    localparam int CORE_REG_BASE   = 'h400;
    localparam int CORE_STRIDE     = 4;
    localparam int CORE_REG_END    = CORE_REG_BASE + NUM_CORES * CORE_STRIDE;

    // Offsets inside one target's block
    localparam int OFF_STATUS  = 0;
    localparam int OFF_MAESTRO = 1;
    localparam int OFF_BAR     = 2;
    localparam int OFF_IER     = 3;

endpackage

/* logic/sysctrl_regs.sv */
// APB slave for full-word accesses only; every transfer stalls with pready low until boot_done
`timescale 1ns/1ps

module sysctrl_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  sysctrl_pkg::addr_t   paddr,
    input  sysctrl_pkg::data_t   pwdata,
    output sysctrl_pkg::data_t   prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 boot_done,
    output logic                 apb_req,
    output sysctrl_pkg::tgt_id_t apb_tgt,
    output sysctrl_pkg::cmd_t    apb_cmd,
    input  logic                 apb_gnt,
    input  logic                 apb_busy,
    input  sysctrl_pkg::cmd_t    tgt_action [sysctrl_pkg::NUM_TARGETS],
    input  logic                 tgt_paused [sysctrl_pkg::NUM_TARGETS],
    input  logic                 tgt_stopped [sysctrl_pkg::NUM_TARGETS],
    input  sysctrl_pkg::addr_t   rst_boot_addr,
    output sysctrl_pkg::addr_t   core_boot_addr [sysctrl_pkg::NUM_CORES],
    input  logic                 periph_irq [sysctrl_pkg::NUM_PERIPHS],
    output logic                 core_irq [sysctrl_pkg::NUM_CORES]
);
    import sysctrl_pkg::*;

    logic [ADDR_WIDTH-3:0]          index;
    logic [ADDR_WIDTH-3:0]          rel;
    logic [1:0]                     off;
    logic                           hit;
    logic                           in_core;
    logic                           is_status;
    logic                           is_maestro;
    logic                           is_bar;
    logic                           is_ier;
    tgt_id_t                        dec_tgt;
    logic [$clog2(NUM_CORES)-1:0]   dec_core;
    data_t                          rd_word;
    logic                           start;
    addr_t                          bar [NUM_CORES];
    data_t                          ier [NUM_CORES];

    // Index into class, slot and offset
    always_comb begin
        index    = paddr[ADDR_WIDTH-1:2];
        rel      = '0;
        off      = '0;
        hit      = 1'b0;
        in_core  = 1'b0;
        dec_tgt  = '0;
        dec_core = '0;
        if (index >= MEM_REG_BASE && index < MEM_REG_END) begin
            rel     = index - (ADDR_WIDTH-2)'(MEM_REG_BASE);
            off     = 2'(rel % MEM_STRIDE);
            dec_tgt = tgt_id_t'(MEM_BASE_ID + rel / MEM_STRIDE);
            hit     = 1'b1;
        end else if (index >= PERIPH_REG_BASE && index < PERIPH_REG_END) begin
            rel     = index - (ADDR_WIDTH-2)'(PERIPH_REG_BASE);
            off     = 2'(rel % PERIPH_STRIDE);
            dec_tgt = tgt_id_t'(PERIPH_BASE_ID + rel / PERIPH_STRIDE);
            hit     = 1'b1;
        end else if (index >= CORE_REG_BASE && index < CORE_REG_END) begin
            rel      = index - (ADDR_WIDTH-2)'(CORE_REG_BASE);
            off      = 2'(rel % CORE_STRIDE);
            dec_core = ($clog2(NUM_CORES))'(rel / CORE_STRIDE);
            dec_tgt  = tgt_id_t'(CORE_BASE_ID + dec_core);
            hit      = 1'b1;
            in_core  = 1'b1;
        end
        is_status  = hit && (off == OFF_STATUS);
        is_maestro = hit && (off == OFF_MAESTRO);
        is_bar     = in_core && (off == OFF_BAR);
        is_ier     = in_core && (off == OFF_IER);
    end

    always_comb begin
        rd_word = '0;
        if (is_status) begin
            rd_word[STAT_PAUSED_BIT]  = tgt_paused[dec_tgt];
            rd_word[STAT_STOPPED_BIT] = tgt_stopped[dec_tgt];
        end else if (is_maestro) begin
            rd_word = data_t'(tgt_action[dec_tgt]);
        end else if (is_bar) begin
            rd_word = data_t'(bar[dec_core]);
        end else if (is_ier) begin
            rd_word = ier[dec_core];
        end
    end

    // New transfer, not yet answered and not waiting on the arbiter
    assign start = psel && !pready && !apb_req && boot_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
            apb_req <= 1'b0;
            for (int c = 0; c < NUM_CORES; c++) begin
                bar[c] <= rst_boot_addr;
                ier[c] <= '0;
            end
        end else if (start) begin
            if (pwrite && is_maestro) begin
                apb_req <= 1'b1;
            end else begin
                pready  <= 1'b1;
                pslverr <= !(is_maestro || is_bar || is_ier || (is_status && !pwrite));
                if (!pwrite) begin
                    prdata <= rd_word;
                end
                if (pwrite && is_bar) begin
                    bar[dec_core] <= pwdata[ADDR_WIDTH-1:0];
                end
                if (pwrite && is_ier) begin
                    ier[dec_core] <= pwdata;
                end
            end
        end else if (apb_req) begin
            if (apb_gnt || apb_busy) begin
                apb_req <= 1'b0;
                pready  <= 1'b1;
                pslverr <= apb_busy;
            end
        end else if (psel && penable && pready) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end
    end

    // Out-of-range codes become no command
    always_ff @(posedge clk) begin
        if (start) begin
            apb_tgt <= dec_tgt;
            apb_cmd <= (pwdata > data_t'(CMD_RESET)) ? CMD_NONE : cmd_t'(pwdata);
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_CORES; c++) begin
            core_boot_addr[c] = bar[c];
            core_irq[c]       = 1'b0;
            for (int p = 0; p < NUM_PERIPHS; p++) begin
                core_irq[c] = core_irq[c] | (ier[c][p] & periph_irq[p]);
            end
        end
    end

    a_err_with_ready: assert property (
        @(posedge clk) disable iff (rst) pslverr |-> pready
    ) else $error("pslverr without pready");

endmodule

/* logic/sysctrl_top.sv */
// Peripheral 0 is this controller and runs from reset; memory 0 and core 0 are started by boot
`timescale 1ns/1ps

module sysctrl_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  sysctrl_pkg::addr_t paddr,
    input  sysctrl_pkg::data_t pwdata,
    output sysctrl_pkg::data_t prdata,
    output logic               pready,
    output logic               pslverr,
    input  sysctrl_pkg::addr_t rst_boot_addr,
    output logic               mem_srst [sysctrl_pkg::NUM_MEMS],
    output logic               mem_pause_req [sysctrl_pkg::NUM_MEMS],
    input  logic               mem_pause_ack [sysctrl_pkg::NUM_MEMS],
    output logic               periph_srst [sysctrl_pkg::NUM_PERIPHS],
    output logic               periph_pause_req [sysctrl_pkg::NUM_PERIPHS],
    input  logic               periph_pause_ack [sysctrl_pkg::NUM_PERIPHS],
    input  logic               periph_irq [sysctrl_pkg::NUM_PERIPHS],
    output logic               core_srst [sysctrl_pkg::NUM_CORES],
    output logic               core_pause_req [sysctrl_pkg::NUM_CORES],
    input  logic               core_pause_ack [sysctrl_pkg::NUM_CORES],
    output sysctrl_pkg::addr_t core_boot_addr [sysctrl_pkg::NUM_CORES],
    output logic               core_irq [sysctrl_pkg::NUM_CORES]
);
    import sysctrl_pkg::*;

    logic    boot_req;
    logic    boot_gnt;
    logic    boot_done;
    tgt_id_t boot_tgt;
    cmd_t    boot_cmd;
    logic    apb_req;
    logic    apb_gnt;
    logic    apb_busy;
    tgt_id_t apb_tgt;
    cmd_t    apb_cmd;
    cmd_t    tgt_cmd;
    logic    tgt_idle [NUM_TARGETS];
    logic    tgt_load [NUM_TARGETS];
    cmd_t    tgt_action [NUM_TARGETS];
    logic    tgt_paused [NUM_TARGETS];
    logic    tgt_stopped [NUM_TARGETS];
    logic    tgt_srst [NUM_TARGETS];
    logic    tgt_pause_req [NUM_TARGETS];
    logic    tgt_pause_ack [NUM_TARGETS];

    // Flat target arrays onto the class ports
    for (genvar i = 0; i < NUM_MEMS; i++) begin : g_mem_map
        assign mem_srst[i]                    = tgt_srst[MEM_BASE_ID + i];
        assign mem_pause_req[i]               = tgt_pause_req[MEM_BASE_ID + i];
        assign tgt_pause_ack[MEM_BASE_ID + i] = mem_pause_ack[i];
    end

    for (genvar i = 0; i < NUM_PERIPHS; i++) begin : g_periph_map
        assign periph_srst[i]                    = tgt_srst[PERIPH_BASE_ID + i];
        assign periph_pause_req[i]               = tgt_pause_req[PERIPH_BASE_ID + i];
        assign tgt_pause_ack[PERIPH_BASE_ID + i] = periph_pause_ack[i];
    end

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core_map
        assign core_srst[i]                    = tgt_srst[CORE_BASE_ID + i];
        assign core_pause_req[i]               = tgt_pause_req[CORE_BASE_ID + i];
        assign tgt_pause_ack[CORE_BASE_ID + i] = core_pause_ack[i];
    end

    sysctrl_regs u_regs (
        .clk            (clk),
        .rst            (rst),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .boot_done      (boot_done),
        .apb_req        (apb_req),
        .apb_tgt        (apb_tgt),
        .apb_cmd        (apb_cmd),
        .apb_gnt        (apb_gnt),
        .apb_busy       (apb_busy),
        .tgt_action     (tgt_action),
        .tgt_paused     (tgt_paused),
        .tgt_stopped    (tgt_stopped),
        .rst_boot_addr  (rst_boot_addr),
        .core_boot_addr (core_boot_addr),
        .periph_irq     (periph_irq),
        .core_irq       (core_irq)
    );

    boot_sequencer u_boot (
        .clk           (clk),
        .rst           (rst),
        .mem0_stopped  (tgt_stopped[MEM_BASE_ID]),
        .core0_stopped (tgt_stopped[CORE_BASE_ID]),
        .boot_req      (boot_req),
        .boot_tgt      (boot_tgt),
        .boot_cmd      (boot_cmd),
        .boot_gnt      (boot_gnt),
        .boot_done     (boot_done)
    );

    maestro_cmd_arbiter u_arb (
        .boot_req (boot_req),
        .boot_tgt (boot_tgt),
        .boot_cmd (boot_cmd),
        .boot_gnt (boot_gnt),
        .apb_req  (apb_req),
        .apb_tgt  (apb_tgt),
        .apb_cmd  (apb_cmd),
        .apb_gnt  (apb_gnt),
        .apb_busy (apb_busy),
        .tgt_idle (tgt_idle),
        .tgt_load (tgt_load),
        .tgt_cmd  (tgt_cmd)
    );

    for (genvar i = 0; i < NUM_TARGETS; i++) begin : g_maestro
        target_maestro #(
            .RUN_AT_RESET (i == PERIPH_BASE_ID)
        ) u_maestro (
            .clk       (clk),
            .rst       (rst),
            .load      (tgt_load[i]),
            .cmd       (tgt_cmd),
            .action    (tgt_action[i]),
            .idle      (tgt_idle[i]),
            .paused    (tgt_paused[i]),
            .stopped   (tgt_stopped[i]),
            .srst      (tgt_srst[i]),
            .pause_req (tgt_pause_req[i]),
            .pause_ack (tgt_pause_ack[i])
        );
    end

endmodule

/* logic/target_maestro.sv */
// Target must raise pause_ack after pause_req rises and drop it after pause_req falls
`timescale 1ns/1ps

module target_maestro #(
    parameter bit RUN_AT_RESET = 1'b0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  sysctrl_pkg::cmd_t cmd,
    output sysctrl_pkg::cmd_t action,
    output logic              idle,
    output logic              paused,
    output logic              stopped,
    output logic              srst,
    output logic              pause_req,
    input  logic              pause_ack
);
    import sysctrl_pkg::*;

    logic handshake_done;

    assign idle           = (action == CMD_NONE);
    assign handshake_done = pause_req && pause_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            action    <= CMD_NONE;
            srst      <= !RUN_AT_RESET;
            pause_req <= 1'b0;
            paused    <= 1'b0;
            stopped   <= !RUN_AT_RESET;
        end else if (load) begin
            action <= cmd;
        end else begin
            case (action)
                CMD_RESUME: begin
                    srst      <= 1'b0;
                    pause_req <= 1'b0;
                    // Wait for the target to release its ack
                    if (!pause_req && !pause_ack) begin
                        action  <= CMD_NONE;
                        paused  <= 1'b0;
                        stopped <= 1'b0;
                    end
                end
                CMD_PAUSE: begin
                    pause_req <= 1'b1;
                    if (handshake_done) begin
                        action <= CMD_NONE;
                        paused <= 1'b1;
                    end
                end
                CMD_STOP, CMD_RESET: begin
                    pause_req <= 1'b1;
                    if (handshake_done) begin
                        srst    <= 1'b1;
                        paused  <= 1'b1;
                        stopped <= 1'b1;
                        // Reset carries on as a resume
                        action  <= (action == CMD_RESET) ? CMD_RESUME : CMD_NONE;
                    end
                end
                default: begin
                    action <= CMD_NONE;
                end
            endcase
        end
    end

    // Arbiter must only load a maestro that has finished its last command
    a_load_only_idle: assert property (
        @(posedge clk) disable iff (rst) load |-> idle
    ) else $error("maestro loaded while busy");

    // Target is held in reset only once it has acknowledged the pause
    a_srst_after_ack: assert property (
        @(posedge clk) disable iff (rst) $rose(srst) |-> pause_ack
    ) else $error("srst raised without pause_ack");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module sysctrl_tb \
    -o sysctrl_sim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/sysctrl_sim > sim.log 2>&1 || { cat sim.log; echo "Run error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

/* test/sysctrl_tb.sv */
// Target model acks one cycle after pause_req; the per-target hold flag blocks that ack
`timescale 1ns/1ps

module sysctrl_tb;
    import sysctrl_pkg::*;

    localparam int OP_READ  = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_POLL  = 2;
    localparam int OP_IRQ   = 3;
    localparam int OP_PINS  = 4;
    localparam int OP_BOOT  = 5;
    localparam int OP_HOLD  = 6;

    localparam addr_t BOOT_ADDR = 16'h8000;
    localparam int    POLL_MAX  = 100;
    localparam int    NUM_RAND  = 4;

    typedef struct {
        int    op;
        addr_t addr;
        data_t wdata;
        data_t exp;
        logic  err;
    } row_t;

    logic  clk;
    logic  rst;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
    data_t prdata;
    logic  pready;
    logic  pslverr;
    addr_t rst_boot_addr;
    logic  mem_srst [NUM_MEMS];
    logic  mem_pause_req [NUM_MEMS];
    logic  mem_pause_ack [NUM_MEMS] = '{default: 1'b0};
    logic  periph_srst [NUM_PERIPHS];
    logic  periph_pause_req [NUM_PERIPHS];
    logic  periph_pause_ack [NUM_PERIPHS] = '{default: 1'b0};
    logic  periph_irq [NUM_PERIPHS];
    logic  core_srst [NUM_CORES];
    logic  core_pause_req [NUM_CORES];
    logic  core_pause_ack [NUM_CORES] = '{default: 1'b0};
    addr_t core_boot_addr [NUM_CORES];
    logic  core_irq [NUM_CORES];

    logic  hold [NUM_TARGETS];
    data_t ier_model [NUM_CORES];
    row_t  rows [$];
    row_t  r;
    logic  table_built;
    logic  row_ok;
    data_t rd;
    logic  er;
    int    n_pass;
    int    n_fail;
    integer seed;
    data_t rand_word;

    sysctrl_top u_dut (
        .clk              (clk),
        .rst              (rst),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .rst_boot_addr    (rst_boot_addr),
        .mem_srst         (mem_srst),
        .mem_pause_req    (mem_pause_req),
        .mem_pause_ack    (mem_pause_ack),
        .periph_srst      (periph_srst),
        .periph_pause_req (periph_pause_req),
        .periph_pause_ack (periph_pause_ack),
        .periph_irq       (periph_irq),
        .core_srst        (core_srst),
        .core_pause_req   (core_pause_req),
        .core_pause_ack   (core_pause_ack),
        .core_boot_addr   (core_boot_addr),
        .core_irq         (core_irq)
    );

    always #10 clk = ~clk;

    // Target response model
    always @(posedge clk) begin
        for (int i = 0; i < NUM_MEMS; i++) begin
            mem_pause_ack[i] <= mem_pause_req[i] && !hold[MEM_BASE_ID + i];
        end
        for (int i = 0; i < NUM_PERIPHS; i++) begin
            periph_pause_ack[i] <= periph_pause_req[i] && !hold[PERIPH_BASE_ID + i];
        end
        for (int i = 0; i < NUM_CORES; i++) begin
            core_pause_ack[i] <= core_pause_req[i] && !hold[CORE_BASE_ID + i];
        end
    end

    function automatic void add_row(int op, addr_t addr, data_t wdata, data_t exp, logic err);
        row_t t;
        t.op    = op;
        t.addr  = addr;
        t.wdata = wdata;
        t.exp   = exp;
        t.err   = err;
        rows.push_back(t);
    endfunction

    function automatic string op_name(int op);
        case (op)
            OP_READ:  return "read";
            OP_WRITE: return "write";
            OP_POLL:  return "poll";
            OP_IRQ:   return "irq";
            OP_PINS:  return "pins";
            OP_BOOT:  return "boot addr";
            default:  return "hold";
        endcase
    endfunction

    // Target pins as {srst, pause_req}, each indexed by flat target id
    function automatic logic [2*NUM_TARGETS-1:0] pin_word();
        logic [2*NUM_TARGETS-1:0] w;
        w = '0;
        for (int i = 0; i < NUM_MEMS; i++) begin
            w[NUM_TARGETS + MEM_BASE_ID + i] = mem_srst[i];
            w[MEM_BASE_ID + i]               = mem_pause_req[i];
        end
        for (int i = 0; i < NUM_PERIPHS; i++) begin
            w[NUM_TARGETS + PERIPH_BASE_ID + i] = periph_srst[i];
            w[PERIPH_BASE_ID + i]               = periph_pause_req[i];
        end
        for (int i = 0; i < NUM_CORES; i++) begin
            w[NUM_TARGETS + CORE_BASE_ID + i] = core_srst[i];
            w[CORE_BASE_ID + i]               = core_pause_req[i];
        end
        return w;
    endfunction

    // Core slot of an IER word address, or -1
    function automatic int ier_core(addr_t addr);
        int idx;
        idx = int'(addr[ADDR_WIDTH-1:2]);
        if (idx >= CORE_REG_BASE && idx < CORE_REG_BASE + NUM_CORES * CORE_STRIDE &&
            (idx - CORE_REG_BASE) % CORE_STRIDE == OFF_IER) begin
            return (idx - CORE_REG_BASE) / CORE_STRIDE;
        end
        return -1;
    endfunction

    task automatic apb_xfer(input logic wr, input addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic poll_until(input addr_t addr, input data_t exp, output logic ok);
        data_t v;
        logic  e;
        int    n;
        ok = 1'b0;
        for (n = 0; n < POLL_MAX && !ok; n++) begin
            apb_xfer(1'b0, addr, '0, v, e);
            ok = (v === exp);
        end
        if (!ok) begin
            $display("Poll of address %h never read %h, last value %h", addr, exp, v);
        end
    endtask

    task automatic check_irq(input logic [NUM_PERIPHS-1:0] pat, output logic ok);
        logic exp_bit;
        @(posedge clk);
        for (int p = 0; p < NUM_PERIPHS; p++) begin
            periph_irq[p] <= pat[p];
        end
        @(negedge clk);
        ok = 1'b1;
        for (int c = 0; c < NUM_CORES; c++) begin
            exp_bit = |(ier_model[c][NUM_PERIPHS-1:0] & pat);
            if (core_irq[c] !== exp_bit) begin
                $display("Error at %0t ns: core_irq[%0d] is %b for pattern %b, expected %b",
                         $time, c, core_irq[c], pat, exp_bit);
                ok = 1'b0;
            end
        end
    endtask

    function automatic void build_table();
        // Boot results, first read stalls until boot is done
        add_row(OP_READ,  16'h0400, 0, 0, 0);
        add_row(OP_READ,  16'h1000, 0, 0, 0);
        add_row(OP_READ,  16'h0800, 0, 0, 0);
        add_row(OP_READ,  16'h0408, 0, 2, 0);
        add_row(OP_READ,  16'h0808, 0, 2, 0);
        add_row(OP_PINS,  0, 0, 16'hBA00, 0);
        add_row(OP_BOOT,  0, 0, BOOT_ADDR, 0);
        add_row(OP_BOOT,  1, 0, BOOT_ADDR, 0);
        // BAR and IER
        add_row(OP_WRITE, 16'h1008, 32'h1234, 0, 0);
        add_row(OP_READ,  16'h1008, 0, 32'h1234, 0);
        add_row(OP_BOOT,  0, 0, 32'h1234, 0);
        add_row(OP_WRITE, 16'h1018, 32'habcd, 0, 0);
        add_row(OP_READ,  16'h1018, 0, 32'habcd, 0);
        add_row(OP_BOOT,  1, 0, 32'habcd, 0);
        add_row(OP_WRITE, 16'h100c, 32'h5, 0, 0);
        add_row(OP_READ,  16'h100c, 0, 32'h5, 0);
        add_row(OP_WRITE, 16'h101c, 32'ha, 0, 0);
        add_row(OP_READ,  16'h101c, 0, 32'ha, 0);
        add_row(OP_IRQ,   0, 4'h1, 0, 0);
        add_row(OP_IRQ,   0, 4'h6, 0, 0);
        add_row(OP_IRQ,   0, 4'h8, 0, 0);
        add_row(OP_IRQ,   0, 4'h0, 0, 0);
        // Memory 1 through resume, pause, stop, reset
        add_row(OP_WRITE, 16'h040c, CMD_RESUME, 0, 0);
        add_row(OP_POLL,  16'h040c, 0, 0, 0);
        add_row(OP_READ,  16'h0408, 0, 0, 0);
        add_row(OP_PINS,  0, 0, 16'hB800, 0);
        add_row(OP_WRITE, 16'h040c, CMD_PAUSE, 0, 0);
        add_row(OP_POLL,  16'h040c, 0, 0, 0);
        add_row(OP_READ,  16'h0408, 0, 1, 0);
        add_row(OP_PINS,  0, 0, 16'hB802, 0);
        add_row(OP_WRITE, 16'h040c, CMD_STOP, 0, 0);
        add_row(OP_POLL,  16'h040c, 0, 0, 0);
        add_row(OP_READ,  16'h0408, 0, 3, 0);
        add_row(OP_PINS,  0, 0, 16'hBA02, 0);
        add_row(OP_WRITE, 16'h040c, CMD_RESET, 0, 0);
        add_row(OP_POLL,  16'h040c, 0, 0, 0);
        add_row(OP_READ,  16'h0408, 0, 0, 0);
        add_row(OP_PINS,  0, 0, 16'hB800, 0);
        // Error cases
        add_row(OP_WRITE, 16'h0400, 32'h1, 0, 1);
        add_row(OP_WRITE, 16'h0040, 32'h1, 0, 1);
        add_row(OP_HOLD,  1, 1, 0, 0);
        add_row(OP_WRITE, 16'h040c, CMD_PAUSE, 0, 0);
        add_row(OP_READ,  16'h040c, 0, CMD_PAUSE, 0);
        add_row(OP_WRITE, 16'h040c, CMD_PAUSE, 0, 1);
        add_row(OP_HOLD,  1, 0, 0, 0);
        add_row(OP_POLL,  16'h040c, 0, 0, 0);
        add_row(OP_WRITE, 16'h040c, 32'h7, 0, 0);
        add_row(OP_READ,  16'h040c, 0, 0, 0);
    endfunction

    initial begin
        table_built = 1'b0;
    end

    initial begin
        wait (table_built);
        repeat (rows.size() * 200 + 1000) @(posedge clk);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        rst_boot_addr = BOOT_ADDR;
        periph_irq    = '{default: 1'b0};
        hold          = '{default: 1'b0};
        ier_model     = '{default: '0};
        n_pass        = 0;
        n_fail        = 0;
        seed          = 32'ha5569abd;
        build_table();
        table_built = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            r      = rows[i];
            row_ok = 1'b1;
            case (r.op)
                OP_READ, OP_WRITE: begin
                    apb_xfer(r.op == OP_WRITE, r.addr, r.wdata, rd, er);
                    if (r.op == OP_READ && rd !== r.exp) begin
                        $display("Error at %0t ns: read of %h gave %h, expected %h",
                                 $time, r.addr, rd, r.exp);
                        row_ok = 1'b0;
                    end
                    if (er !== r.err) begin
                        $display("Error at %0t ns: pslverr at %h is %b, expected %b",
                                 $time, r.addr, er, r.err);
                        row_ok = 1'b0;
                    end
                    if (r.op == OP_WRITE && !er && ier_core(r.addr) >= 0) begin
                        ier_model[ier_core(r.addr)] = r.wdata;
                    end
                end
                OP_POLL: begin
                    poll_until(r.addr, r.exp, row_ok);
                end
                OP_IRQ: begin
                    check_irq(r.wdata[NUM_PERIPHS-1:0], row_ok);
                end
                OP_PINS: begin
                    @(negedge clk);
                    if (pin_word() !== r.exp[2*NUM_TARGETS-1:0]) begin
                        $display("Error at %0t ns: target pins are %b, expected %b",
                                 $time, pin_word(), r.exp[2*NUM_TARGETS-1:0]);
                        row_ok = 1'b0;
                    end
                end
                OP_BOOT: begin
                    @(negedge clk);
                    if (core_boot_addr[r.addr] !== r.exp[ADDR_WIDTH-1:0]) begin
                        $display("Error at %0t ns: core_boot_addr[%0d] is %h, expected %h",
                                 $time, r.addr, core_boot_addr[r.addr], r.exp[ADDR_WIDTH-1:0]);
                        row_ok = 1'b0;
                    end
                end
                default: begin
                    @(posedge clk);
                    hold[r.addr] <= r.wdata[0];
                end
            endcase
            if (row_ok) begin
                n_pass++;
            end else begin
                n_fail++;
            end
            $display("Test %0d %s at %h: %s", i, op_name(r.op), r.addr,
                     row_ok ? "pass" : "FAIL");
        end

        // Extra irq patterns on top of the table
        for (int k = 0; k < NUM_RAND; k++) begin
            rand_word = $random(seed);
            check_irq(rand_word[NUM_PERIPHS-1:0], row_ok);
            if (row_ok) begin
                n_pass++;
            end else begin
                n_fail++;
            end
            $display("Test random irq %b: %s", rand_word[NUM_PERIPHS-1:0],
                     row_ok ? "pass" : "FAIL");
        end

        $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/sysctrl_pkg.sv
logic/target_maestro.sv
logic/maestro_cmd_arbiter.sv
logic/boot_sequencer.sv
logic/sysctrl_regs.sv
logic/sysctrl_top.sv
test/sysctrl_tb.sv
